// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP = scc_mgr_tb
FILELIST = build.f
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
verilog/scc_bus_pkg.sv
verilog/scc_cfg_pkg.sv
verilog/scc_avl_decode.sv
verilog/scc_setting_file.sv
verilog/scc_sample_counter.sv
verilog/scc_scan_chain.sv
verilog/scc_mgr_top.sv
tests/scc_mgr_tb.sv

// File: tests/scc_mgr_tb.sv
`timescale 1ns/1ns
// testbench of the scan-chain configuration manager
// drives the Avalon slave, keeps a reference model of settings, group counter
// and sample counters, and checks readback and serial scan output
module scc_mgr_tb
	import scc_bus_pkg::*, scc_cfg_pkg::*;
();

	localparam int n_rand = 24;
	localparam int io_pins = entries - io_base;
	localparam int cnt_top = 2 ** (sample_w - 1) - 1;
	localparam int cnt_bottom = -(2 ** (sample_w - 1));
	// cycle budget per transfer kind, then per test
	localparam int rf_cycles = rf_latency + 3;
	localparam int scan_cycles = dqs_scan_bits + 8;
	localparam int t1_len = 12 * rf_cycles;
	localparam int t2_len = 2 * n_rand * rf_cycles;
	localparam int t3_len = 4 * 3 + 3 * rf_cycles + 2 * scan_cycles;
	localparam int t4_len = 9 * rf_cycles + 5 * scan_cycles;
	localparam int t5_len = 30 * 4;
	localparam int max_cycles = 8 + t1_len + t2_len + t3_len + t4_len + t5_len + 100;

	logic avl_clk;
	logic avl_reset_n;
	logic [avl_addr_w-1:0] avl_address;
	logic avl_write;
	logic [avl_data_w-1:0] avl_writedata;
	logic avl_read;
	logic [avl_data_w-1:0] avl_readdata;
	logic avl_waitrequest;
	logic [dqs_groups-1:0] capture_strobe_tracking;
	logic scc_data;
	logic [dqs_groups-1:0] dqs_ena;
	logic [dqs_groups-1:0] dqs_io_ena;
	logic [dq_width-1:0] dq_ena;
	logic [dm_width-1:0] dm_ena;
	logic scc_upd;

	// reference model
	logic [word_w-1:0] ref_mem [entries];
	logic [7:0] ref_gc;
	int ref_cnt [dqs_groups];

	logic [31:0] rng;
	logic scan_active;
	int checks;
	int fails;
	int cycle_count;
	int wf [n_rand];
	int wi [n_rand];

	scc_mgr_top uut (
		.avl_clk                 (avl_clk),
		.avl_reset_n             (avl_reset_n),
		.avl_address             (avl_address),
		.avl_write               (avl_write),
		.avl_writedata           (avl_writedata),
		.avl_read                (avl_read),
		.avl_readdata            (avl_readdata),
		.avl_waitrequest         (avl_waitrequest),
		.capture_strobe_tracking (capture_strobe_tracking),
		.scc_data                (scc_data),
		.dqs_ena                 (dqs_ena),
		.dqs_io_ena              (dqs_io_ena),
		.dq_ena                  (dq_ena),
		.dm_ena                  (dm_ena),
		.scc_upd                 (scc_upd)
	);

	initial
	begin
		avl_clk = 1'b0;
		forever #2 avl_clk = ~avl_clk;
	end

	always @(posedge avl_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles)
		begin
			$display("timeout: a transfer or scan did not complete within %0d cycles", max_cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	a_idle_ready: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		!(avl_read || avl_write) |-> !avl_waitrequest)
	else
	begin
		$display("waitrequest is high while no transfer is held");
		fails++;
	end

	a_outputs_quiet: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		!scan_active |-> !scc_data && !scc_upd && (dqs_ena == '0) && (dqs_io_ena == '0)
		&& (dq_ena == '0) && (dm_ena == '0))
	else
	begin
		$display("a serial output is active while no scan is running");
		fails++;
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [9:0] addr_of(input logic [3:0] sec, input logic [5:0] idx);
		return {sec, idx};
	endfunction

	function automatic int entry_of(input int f, input int idx);
		return (f >= io_field_first) ? io_base + idx : idx;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			fails++;
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("%-36s %s", name, (fails == fails_before) ? "ok" : "failed");
	endtask

	task automatic bus_write(input logic [9:0] addr, input logic [31:0] data);
		@(posedge avl_clk);
		avl_address <= addr;
		avl_writedata <= data;
		avl_write <= 1'b1;
		do
			@(negedge avl_clk);
		while (avl_waitrequest);
		@(posedge avl_clk);
		avl_write <= 1'b0;
	endtask

	task automatic bus_read(input logic [9:0] addr, output logic [31:0] data);
		@(posedge avl_clk);
		avl_address <= addr;
		avl_read <= 1'b1;
		do
			@(negedge avl_clk);
		while (avl_waitrequest);
		data = avl_readdata;
		@(posedge avl_clk);
		avl_read <= 1'b0;
	endtask

	task automatic field_write(input int f, input int idx, input logic [31:0] value);
		int e;
		logic [word_w-1:0] mask;
		e = entry_of(f, idx);
		mask = word_w'((1 << field_width[f]) - 1);
		// only the field's own bits change
		ref_mem[e] = (ref_mem[e] & ~(mask << field_offset[f]))
			| ((value[word_w-1:0] & mask) << field_offset[f]);
		bus_write(addr_of(4'(f), 6'(idx)), value);
	endtask

	task automatic field_check(input int f, input int idx);
		logic [31:0] got;
		logic [word_w-1:0] mask;
		mask = word_w'((1 << field_width[f]) - 1);
		bus_read(addr_of(4'(f), 6'(idx)), got);
		check_value($sformatf("avl_readdata field%0d[%0d]", f, idx), got,
			32'((ref_mem[entry_of(f, idx)] >> field_offset[f]) & mask));
	endtask

	task automatic group_check();
		logic [31:0] got;
		bus_read(addr_of(sec_group, 6'd0), got);
		check_value("avl_readdata group_counter", got, 32'(ref_gc));
	endtask

	task automatic counter_write(input int g, input logic [31:0] value);
		ref_cnt[g] = $signed(value[sample_w-1:0]);
		bus_write(addr_of(sec_track, 6'(g)), value);
	endtask

	task automatic counter_sample(input logic [7:0] tgt);
		bus_write(addr_of(sec_track, sample_index), 32'(tgt));
		for (int g = 0; g < dqs_groups; g++)
			if ((tgt == broadcast_sel) || (int'(tgt) == g))
			begin
				if (capture_strobe_tracking[g])
					ref_cnt[g] = (ref_cnt[g] >= cnt_top) ? cnt_top : ref_cnt[g] + 1;
				else
					ref_cnt[g] = (ref_cnt[g] <= cnt_bottom) ? cnt_bottom : ref_cnt[g] - 1;
			end
	endtask

	task automatic counter_check(input int g);
		logic [31:0] got;
		bus_read(addr_of(sec_track, 6'(g)), got);
		check_value($sformatf("avl_readdata counter%0d", g), got, 32'(ref_cnt[g]));
	endtask

	// runs one scan and collects scc_data while any enable is high
	task automatic run_scan(input scan_op_t op, input logic [7:0] tgt);
		int t;
		int gc;
		int e;
		int nbits;
		int got_bits;
		int pulses;
		logic bcast;
		logic [dqs_groups-1:0] exp_dqs;
		logic [dqs_groups-1:0] exp_dqs_io;
		logic [dq_width-1:0] exp_dq;
		logic [dm_width-1:0] exp_dm;
		logic [word_w-1:0] exp_word;
		logic [word_w-1:0] shifted;
		bcast = (tgt == broadcast_sel);
		t = bcast ? 0 : int'(tgt);
		gc = int'(ref_gc);
		exp_dqs = '0;
		exp_dqs_io = '0;
		exp_dq = '0;
		exp_dm = '0;
		e = 0;
		nbits = io_scan_bits;
		case (op)
			scan_dqs:
			begin
				e = t;
				nbits = dqs_scan_bits;
				exp_dqs = bcast ? '1 : dqs_groups'(1 << t);
			end
			scan_dq_io:
			begin
				e = io_base + t;
				exp_dq = dq_width'(bcast ? (1 << dq_per_dqs) - 1 : 1 << t) << (gc * dq_per_dqs);
			end
			scan_dqs_io:
			begin
				e = io_base + dq_per_dqs;
				exp_dqs_io = bcast ? '1 : dqs_groups'(1 << gc);
			end
			scan_dm_io:
			begin
				e = io_base + dq_per_dqs + 1;
				exp_dm = dm_width'(1 << gc);
			end
			default: nbits = 0;
		endcase
		exp_word = ref_mem[e] & word_w'((1 << nbits) - 1);
		shifted = '0;
		got_bits = 0;
		pulses = 0;
		@(posedge avl_clk);
		avl_address <= addr_of(sec_scan, 6'(op));
		avl_writedata <= 32'(tgt);
		avl_write <= 1'b1;
		scan_active <= 1'b1;
		do
		begin
			@(negedge avl_clk);
			if (scc_upd)
				pulses++;
			if ({dqs_ena, dqs_io_ena, dq_ena, dm_ena} != '0)
			begin
				check_value("{dqs_ena,dqs_io_ena,dq_ena,dm_ena}",
					32'({dqs_ena, dqs_io_ena, dq_ena, dm_ena}),
					32'({exp_dqs, exp_dqs_io, exp_dq, exp_dm}));
				shifted = {shifted[word_w-2:0], scc_data};
				got_bits++;
			end
		end
		while (avl_waitrequest);
		@(posedge avl_clk);
		avl_write <= 1'b0;
		scan_active <= 1'b0;
		check_value("scan bit count", got_bits, nbits);
		check_value("scc_data word", 32'(shifted), 32'(exp_word));
		check_value("scc_upd pulses", pulses, (op == scan_upd) ? 1 : 0);
	endtask

	initial
	begin
		int t;
		int t_fail;
		avl_reset_n = 1'b0;
		avl_address = '0;
		avl_write = 1'b0;
		avl_writedata = '0;
		avl_read = 1'b0;
		capture_strobe_tracking = '0;
		scan_active = 1'b0;
		checks = 0;
		fails = 0;
		cycle_count = 0;
		rng = 32'h12c1;
		ref_gc = '0;
		for (int i = 0; i < entries; i++)
			ref_mem[i] = '0;
		for (int g = 0; g < dqs_groups; g++)
			ref_cnt[g] = 0;

		t_fail = 0;
		@(negedge avl_clk);
		check_value("avl_waitrequest in reset", 32'(avl_waitrequest), 32'd1);
		repeat (4) @(posedge avl_clk);
		avl_reset_n <= 1'b1;
		@(negedge avl_clk);
		check_value("avl_waitrequest idle", 32'(avl_waitrequest), 32'd0);
		for (int f = 1; f <= 9; f++)
			field_check(f, 0);
		field_check(1, dqs_groups - 1);
		field_check(9, io_pins - 1);
		report_test("test 1 reset state", t_fail);

		t_fail = fails;
		for (int i = 0; i < n_rand; i++)
		begin
			rng = next_random(rng);
			wf[i] = 1 + int'(rng % 9);
			rng = next_random(rng);
			wi[i] = (wf[i] >= io_field_first) ? int'(rng % io_pins) : int'(rng % dqs_groups);
			rng = next_random(rng);
			field_write(wf[i], wi[i], rng);
		end
		for (int i = 0; i < n_rand; i++)
			field_check(wf[i], wi[i]);
		report_test("test 2 random field access", t_fail);

		t_fail = fails;
		rng = next_random(rng);
		ref_gc = rng[7:0];
		bus_write(addr_of(sec_group, 6'd0), 32'(ref_gc));
		group_check();
		ref_gc = 8'd1;
		bus_write(addr_of(sec_group, 6'd0), 32'(ref_gc));
		group_check();
		rng = next_random(rng);
		t = int'(rng % dq_per_dqs);
		for (int f = io_field_first; f <= 9; f++)
		begin
			rng = next_random(rng);
			field_write(f, t, rng);
		end
		run_scan(scan_dq_io, 8'(t));
		run_scan(scan_dq_io, broadcast_sel);
		report_test("test 3 group counter and dq scan", t_fail);

		t_fail = fails;
		for (int f = 1; f < io_field_first; f++)
			field_write(f, 1, 32'(24'hB4D269 >> field_offset[f]));
		run_scan(scan_dqs, 8'd1);
		run_scan(scan_dqs, broadcast_sel);
		for (int f = io_field_first; f <= 9; f++)
			field_write(f, dq_per_dqs, 32'(11'h5A3 >> field_offset[f]));
		run_scan(scan_dqs_io, 8'd0);
		run_scan(scan_dm_io, 8'd0);
		run_scan(scan_upd, 8'd0);
		report_test("test 4 scan shift and update", t_fail);

		t_fail = fails;
		counter_write(0, 32'(cnt_top - 3));
		@(posedge avl_clk);
		capture_strobe_tracking <= '1;
		repeat (6) counter_sample(8'd0);
		counter_check(0);
		counter_write(1, 32'(cnt_bottom + 3));
		@(posedge avl_clk);
		capture_strobe_tracking <= '0;
		repeat (6) counter_sample(8'd1);
		counter_check(1);
		counter_check(0);
		// group 0 steps up and group 1 steps down
		rng = next_random(rng);
		counter_write(0, 32'(rng[11:0]));
		counter_write(1, 32'(-int'(rng[23:12])));
		@(posedge avl_clk);
		capture_strobe_tracking <= 2'b01;
		repeat (3) counter_sample(broadcast_sel);
		counter_check(0);
		counter_check(1);
		report_test("test 5 sample counters", t_fail);

		$display("%0d value checks, %0d failures", checks, fails);
		if (fails == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: verilog/scc_avl_decode.sv
`timescale 1ns/1ns
// Avalon-MM slave decoder of the scan-chain manager
// splits the address into sections, builds waitrequest and readdata,
// and issues requests to the setting file, sample counters and scan engine
module scc_avl_decode
	import scc_bus_pkg::*, scc_cfg_pkg::*;
(
	input  logic                  avl_clk,
	input  logic                  avl_reset_n,
	input  logic [avl_addr_w-1:0] avl_address,
	input  logic                  avl_write,
	input  logic [avl_data_w-1:0] avl_writedata,
	input  logic                  avl_read,
	output logic [avl_data_w-1:0] avl_readdata,
	output logic                  avl_waitrequest,
	input  logic                  rf_done,
	input  logic [avl_data_w-1:0] rf_rdata,
	output logic                  rf_start,
	output logic                  rf_write,
	output logic [3:0]            rf_field,
	output logic [5:0]            rf_index,
	output logic [avl_data_w-1:0] wdata,
	input  logic [avl_data_w-1:0] cnt_rdata,
	output logic                  cnt_access,
	output logic                  cnt_write,
	output logic                  cnt_sample,
	output logic [5:0]            cnt_index,
	input  logic                  scan_ack,
	output logic                  scan_req,
	output scan_op_t              scan_op,
	output logic [7:0]            scan_target,
	output logic [7:0]            group_counter
);

	section_t section;
	logic [5:0] index;
	logic active;
	logic is_field;
	logic rf_busy;
	logic trk_wait;
	logic scan_start;

	assign section = section_t'(avl_address[9:6]);
	assign index = avl_address[5:0];
	assign active = avl_read || avl_write;
	assign is_field = (section >= sec_field1) && (section <= sec_field9);

	assign rf_start = active && is_field && !rf_busy;
	assign rf_write = avl_write;
	assign rf_field = avl_address[9:6];
	assign rf_index = index;
	assign wdata = avl_writedata;

	// counter write or sample lands at the end of the second cycle
	assign cnt_access = active && (section == sec_track) && trk_wait;
	assign cnt_write = avl_write;
	assign cnt_sample = (index == sample_index);
	assign cnt_index = index;

	// no new scan while the previous handshake is still closing
	assign scan_start = avl_write && (section == sec_scan) && !scan_req && !scan_ack;

	always_comb
	begin
		avl_waitrequest = 1'b0;
		if (!avl_reset_n)
			avl_waitrequest = 1'b1;
		else if (active)
		begin
			if (is_field)
				avl_waitrequest = !rf_done;
			else if (section == sec_track)
				avl_waitrequest = !trk_wait;
			else if ((section == sec_scan) && avl_write)
				avl_waitrequest = !(scan_req && scan_ack);
		end
	end

	always_comb
	begin
		if (is_field)
			avl_readdata = rf_rdata;
		else if (section == sec_group)
			avl_readdata = avl_data_w'(group_counter);
		else if (section == sec_track)
			avl_readdata = cnt_rdata;
		else
			avl_readdata = '0;
	end

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			group_counter <= '0;
			rf_busy <= 1'b0;
			trk_wait <= 1'b0;
			scan_req <= 1'b0;
		end
		else
		begin
			if (avl_write && (section == sec_group))
				group_counter <= avl_writedata[7:0];
			if (rf_start)
				rf_busy <= 1'b1;
			else if (rf_done)
				rf_busy <= 1'b0;
			trk_wait <= active && (section == sec_track) && !trk_wait;
			if (scan_start)
				scan_req <= 1'b1;
			else if (scan_ack)
				scan_req <= 1'b0;
		end
	end

	always_ff @(posedge avl_clk)
	begin
		if (scan_start)
		begin
			scan_op <= scan_op_t'(avl_address[3:0]);
			scan_target <= avl_writedata[7:0];
		end
	end

	// targets are checked once the request reaches the scan engine
	a_dqs_target: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		$rose(scan_req) && (scan_op == scan_dqs)
		|-> (scan_target == broadcast_sel) || (scan_target < dqs_groups));

	a_dq_target: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		$rose(scan_req) && (scan_op == scan_dq_io)
		|-> (scan_target == broadcast_sel) || (scan_target < dq_per_dqs));

endmodule

// File: verilog/scc_bus_pkg.sv
// scan-chain manager bus definitions
// Avalon slave address map, section codes and scan opcodes
package scc_bus_pkg;

	localparam int avl_addr_w = 10;
	localparam int avl_data_w = 32;

	// address bits 9:6
	typedef enum logic [3:0] {
		sec_group  = 4'd0,
		sec_field1 = 4'd1,
		sec_field2 = 4'd2,
		sec_field3 = 4'd3,
		sec_field4 = 4'd4,
		sec_field5 = 4'd5,
		sec_field6 = 4'd6,
		sec_field7 = 4'd7,
		sec_field8 = 4'd8,
		sec_field9 = 4'd9,
		sec_scan   = 4'd14,
		sec_track  = 4'd15
	} section_t;

	// address bits 3:0 inside sec_scan
	typedef enum logic [3:0] {
		scan_dqs    = 4'd0,
		scan_dqs_io = 4'd1,
		scan_dq_io  = 4'd2,
		scan_dm_io  = 4'd3,
		scan_upd    = 4'd8
	} scan_op_t;

	localparam logic [7:0] broadcast_sel = 8'hFF;
	localparam logic [5:0] sample_index = 6'd63;
	localparam int rf_latency = 3;

endpackage

// File: verilog/scc_cfg_pkg.sv
// scan-chain manager configuration
// memory geometry, setting-word layout and per-field tables
package scc_cfg_pkg;

	localparam int dqs_groups = 2;
	localparam int dq_per_dqs = 8;
	localparam int dm_per_dqs = 1;
	localparam int dq_width = dqs_groups * dq_per_dqs;
	localparam int dm_width = dqs_groups * dm_per_dqs;

	localparam int word_w = 24;

	// dqs group words come first, then the I/O words of the selected group
	localparam int io_base = dqs_groups;
	// dq pins occupy 0..7 of the I/O region
	localparam int io_dqs_pin = dq_per_dqs;
	localparam int io_dm_pin = dq_per_dqs + 1;
	localparam int entries = io_base + dq_per_dqs + 1 + dm_per_dqs;
	localparam int rf_addr_w = 4;

	localparam int dqs_scan_bits = 24;
	localparam int io_scan_bits = 11;

	// fields 1..6 live in group words, 7..9 in I/O words
	localparam int field_offset [1:9] = '{0, 4, 8, 12, 17, 21, 0, 4, 7};
	localparam int field_width [1:9] = '{4, 4, 4, 5, 4, 3, 4, 3, 4};
	localparam int io_field_first = 7;

	localparam int sample_w = 14;

endpackage

// File: verilog/scc_mgr_top.sv
`timescale 1ns/1ns
// scan-chain configuration manager
// Avalon-MM slave that stores I/O delay settings and scans them into the chains
module scc_mgr_top
	import scc_bus_pkg::*, scc_cfg_pkg::*;
(
	input  logic                  avl_clk,
	input  logic                  avl_reset_n,
	input  logic [avl_addr_w-1:0] avl_address,
	input  logic                  avl_write,
	input  logic [avl_data_w-1:0] avl_writedata,
	input  logic                  avl_read,
	output logic [avl_data_w-1:0] avl_readdata,
	output logic                  avl_waitrequest,
	input  logic [dqs_groups-1:0] capture_strobe_tracking,
	output logic                  scc_data,
	output logic [dqs_groups-1:0] dqs_ena,
	output logic [dqs_groups-1:0] dqs_io_ena,
	output logic [dq_width-1:0]   dq_ena,
	output logic [dm_width-1:0]   dm_ena,
	output logic                  scc_upd
);

	logic rf_start;
	logic rf_write;
	logic [3:0] rf_field;
	logic [5:0] rf_index;
	logic [avl_data_w-1:0] wdata;
	logic rf_done;
	logic [avl_data_w-1:0] rf_rdata;
	logic cnt_access;
	logic cnt_write;
	logic cnt_sample;
	logic [5:0] cnt_index;
	logic [avl_data_w-1:0] cnt_rdata;
	logic scan_req;
	logic scan_ack;
	scan_op_t scan_op;
	logic [7:0] scan_target;
	logic [7:0] group_counter;
	logic [rf_addr_w-1:0] scan_entry;
	logic [word_w-1:0] scan_word;

	scc_avl_decode u_decode (
		.avl_clk         (avl_clk),
		.avl_reset_n     (avl_reset_n),
		.avl_address     (avl_address),
		.avl_write       (avl_write),
		.avl_writedata   (avl_writedata),
		.avl_read        (avl_read),
		.avl_readdata    (avl_readdata),
		.avl_waitrequest (avl_waitrequest),
		.rf_done         (rf_done),
		.rf_rdata        (rf_rdata),
		.rf_start        (rf_start),
		.rf_write        (rf_write),
		.rf_field        (rf_field),
		.rf_index        (rf_index),
		.wdata           (wdata),
		.cnt_rdata       (cnt_rdata),
		.cnt_access      (cnt_access),
		.cnt_write       (cnt_write),
		.cnt_sample      (cnt_sample),
		.cnt_index       (cnt_index),
		.scan_ack        (scan_ack),
		.scan_req        (scan_req),
		.scan_op         (scan_op),
		.scan_target     (scan_target),
		.group_counter   (group_counter)
	);

	scc_setting_file u_setting (
		.avl_clk     (avl_clk),
		.avl_reset_n (avl_reset_n),
		.rf_start    (rf_start),
		.rf_write    (rf_write),
		.rf_field    (rf_field),
		.rf_index    (rf_index),
		.wdata       (wdata),
		.scan_entry  (scan_entry),
		.rf_done     (rf_done),
		.rf_rdata    (rf_rdata),
		.scan_word   (scan_word)
	);

	scc_sample_counter u_counter (
		.avl_clk                 (avl_clk),
		.avl_reset_n             (avl_reset_n),
		.cnt_access              (cnt_access),
		.cnt_write               (cnt_write),
		.cnt_sample              (cnt_sample),
		.cnt_index               (cnt_index),
		.wdata                   (wdata),
		.capture_strobe_tracking (capture_strobe_tracking),
		.cnt_rdata               (cnt_rdata)
	);

	scc_scan_chain u_scan (
		.avl_clk       (avl_clk),
		.avl_reset_n   (avl_reset_n),
		.scan_req      (scan_req),
		.scan_op       (scan_op),
		.scan_target   (scan_target),
		.group_counter (group_counter),
		.scan_word     (scan_word),
		.scan_ack      (scan_ack),
		.scan_entry    (scan_entry),
		.scc_data      (scc_data),
		.dqs_ena       (dqs_ena),
		.dqs_io_ena    (dqs_io_ena),
		.dq_ena        (dq_ena),
		.dm_ena        (dm_ena),
		.scc_upd       (scc_upd)
	);

endmodule

// File: verilog/scc_sample_counter.sv
`timescale 1ns/1ns
// DQS-tracking sample counters
// one signed saturating counter per group, stepped by the registered strobe
module scc_sample_counter
	import scc_bus_pkg::*, scc_cfg_pkg::*;
(
	input  logic                  avl_clk,
	input  logic                  avl_reset_n,
	input  logic                  cnt_access,
	input  logic                  cnt_write,
	input  logic                  cnt_sample,
	input  logic [5:0]            cnt_index,
	input  logic [avl_data_w-1:0] wdata,
	input  logic [dqs_groups-1:0] capture_strobe_tracking,
	output logic [avl_data_w-1:0] cnt_rdata
);

	logic [dqs_groups-1:0] strobe_r;
	logic signed [sample_w-1:0] cnt [dqs_groups];
	logic signed [sample_w-1:0] rd_cnt;
	logic signed [sample_w-1:0] cnt_max;
	logic signed [sample_w-1:0] cnt_min;
	logic [7:0] tgt;

	assign cnt_max = {1'b0, {(sample_w-1){1'b1}}};
	assign cnt_min = {1'b1, {(sample_w-1){1'b0}}};
	assign tgt = wdata[7:0];

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			strobe_r <= '0;
			for (int g = 0; g < dqs_groups; g++)
				cnt[g] <= '0;
		end
		else
		begin
			strobe_r <= capture_strobe_tracking;
			for (int g = 0; g < dqs_groups; g++)
			begin
				if (cnt_access && cnt_write && !cnt_sample && (cnt_index == 6'(g)))
					cnt[g] <= wdata[sample_w-1:0];
				else if (cnt_access && cnt_write && cnt_sample &&
					((tgt == broadcast_sel) || (tgt == 8'(g))))
				begin
					// up on strobe high, down on low, both saturating
					if (strobe_r[g] && (cnt[g] != cnt_max))
						cnt[g] <= cnt[g] + 1'b1;
					else if (!strobe_r[g] && (cnt[g] != cnt_min))
						cnt[g] <= cnt[g] - 1'b1;
				end
			end
		end
	end

	always_comb
	begin
		rd_cnt = '0;
		for (int g = 0; g < dqs_groups; g++)
			if (cnt_index == 6'(g))
				rd_cnt = cnt[g];
		cnt_rdata = {{(avl_data_w-sample_w){rd_cnt[sample_w-1]}}, rd_cnt};
	end

endmodule

// File: verilog/scc_scan_chain.sv
`timescale 1ns/1ns
// scan engine
// shifts one setting word out on scc_data, msb first, with its enable pattern,
// or issues a single update pulse
module scc_scan_chain
	import scc_bus_pkg::*, scc_cfg_pkg::*;
(
	input  logic                  avl_clk,
	input  logic                  avl_reset_n,
	input  logic                  scan_req,
	input  scan_op_t              scan_op,
	input  logic [7:0]            scan_target,
	input  logic [7:0]            group_counter,
	input  logic [word_w-1:0]     scan_word,
	output logic                  scan_ack,
	output logic [rf_addr_w-1:0]  scan_entry,
	output logic                  scc_data,
	output logic [dqs_groups-1:0] dqs_ena,
	output logic [dqs_groups-1:0] dqs_io_ena,
	output logic [dq_width-1:0]   dq_ena,
	output logic [dm_width-1:0]   dm_ena,
	output logic                  scc_upd
);

	typedef enum logic [1:0] {
		idle,
		fetch,
		load,
		done
	} scan_state_t;

	scan_state_t state;
	logic [7:0] bit_cnt;
	logic [word_w-1:0] sh;
	logic bcast;
	logic is_dqs;
	logic shift_op;
	int tgt_idx;
	int gc;

	assign bcast = (scan_target == broadcast_sel);
	assign is_dqs = (scan_op == scan_dqs);
	assign shift_op = scan_op inside {scan_dqs, scan_dqs_io, scan_dq_io, scan_dm_io};
	assign tgt_idx = bcast ? 0 : int'(scan_target);
	assign gc = int'(group_counter);
	assign scan_ack = (state == done);

	always_comb
	begin
		case (scan_op)
			scan_dqs: scan_entry = rf_addr_w'(tgt_idx);
			scan_dq_io: scan_entry = rf_addr_w'(io_base + tgt_idx);
			scan_dqs_io: scan_entry = rf_addr_w'(io_base + io_dqs_pin);
			scan_dm_io: scan_entry = rf_addr_w'(io_base + io_dm_pin);
			default: scan_entry = '0;
		endcase
	end

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			state <= idle;
			bit_cnt <= '0;
			scc_upd <= 1'b0;
		end
		else
		begin
			scc_upd <= 1'b0;
			case (state)
				idle:
					if (scan_req)
					begin
						if (shift_op)
							state <= fetch;
						else
						begin
							// update and unknown opcodes finish at once
							state <= done;
							scc_upd <= (scan_op == scan_upd);
						end
					end
				fetch:
				begin
					state <= load;
					bit_cnt <= is_dqs ? 8'(dqs_scan_bits - 1) : 8'(io_scan_bits - 1);
				end
				load:
					if (bit_cnt == '0)
						state <= done;
					else
						bit_cnt <= bit_cnt - 1'b1;
				done:
					if (!scan_req)
						state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// io words use only their low bits, so left-align before shifting
	always_ff @(posedge avl_clk)
	begin
		if (state == fetch)
			sh <= scan_word << (word_w - (is_dqs ? dqs_scan_bits : io_scan_bits));
		else if (state == load)
			sh <= sh << 1;
	end

	always_comb
	begin
		scc_data = 1'b0;
		dqs_ena = '0;
		dqs_io_ena = '0;
		dq_ena = '0;
		dm_ena = '0;
		if (state == load)
		begin
			scc_data = sh[word_w-1];
			case (scan_op)
				scan_dqs:
					dqs_ena = bcast ? '1 : (dqs_groups'(1) << tgt_idx);
				scan_dqs_io:
					dqs_io_ena = bcast ? '1 : (dqs_groups'(1) << gc);
				scan_dq_io:
					if (bcast)
						dq_ena = dq_width'({dq_per_dqs{1'b1}}) << (gc * dq_per_dqs);
					else
						dq_ena = dq_width'(1) << (gc * dq_per_dqs + tgt_idx);
				scan_dm_io:
					dm_ena = dm_width'({dm_per_dqs{1'b1}}) << (gc * dm_per_dqs);
				default: ;
			endcase
		end
	end

	// the decoder must keep its request up for the whole shift
	a_no_ack_in_load: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		(state == load) |-> scan_req);

endmodule

// File: verilog/scc_setting_file.sv
`timescale 1ns/1ns
// delay-setting register file
// masked read-modify-write of single fields, plus a read port for the scan engine
module scc_setting_file
	import scc_bus_pkg::*, scc_cfg_pkg::*;
(
	input  logic                  avl_clk,
	input  logic                  avl_reset_n,
	input  logic                  rf_start,
	input  logic                  rf_write,
	input  logic [3:0]            rf_field,
	input  logic [5:0]            rf_index,
	input  logic [avl_data_w-1:0] wdata,
	input  logic [rf_addr_w-1:0]  scan_entry,
	output logic                  rf_done,
	output logic [avl_data_w-1:0] rf_rdata,
	output logic [word_w-1:0]     scan_word
);

	logic [rf_latency-1:0] lat;
	logic [word_w-1:0] mem [entries];
	logic [word_w-1:0] rd_word;
	logic [rf_addr_w-1:0] entry;
	logic [3:0] fsel;
	int off;
	logic [word_w-1:0] fmask;
	logic [word_w-1:0] merged;

	assign rf_done = lat[rf_latency-1];

	always_comb
	begin
		fsel = ((rf_field >= 4'd1) && (rf_field <= 4'd9)) ? rf_field : 4'd1;
		off = field_offset[fsel];
		fmask = (word_w'(1) << field_width[fsel]) - word_w'(1);
		if (rf_field >= io_field_first)
			entry = rf_addr_w'(io_base + int'(rf_index));
		else
			entry = rf_addr_w'(rf_index);
		merged = (rd_word & ~(fmask << off)) | ((wdata[word_w-1:0] & fmask) << off);
	end

	assign rf_rdata = avl_data_w'((rd_word >> off) & fmask);

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			lat <= '0;
			for (int i = 0; i < entries; i++)
				mem[i] <= '0;
		end
		else
		begin
			lat <= {lat[rf_latency-2:0], rf_start};
			// merged word goes in one cycle before rf_done
			if (rf_write && lat[rf_latency-2] && (int'(entry) < entries))
				mem[entry] <= merged;
		end
	end

	always_ff @(posedge avl_clk)
	begin
		rd_word <= (int'(entry) < entries) ? mem[entry] : '0;
		scan_word <= (int'(scan_entry) < entries) ? mem[scan_entry] : '0;
	end

	// the master holds the address for the whole access
	a_index_stable: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		(|lat) |-> $stable(rf_index));

endmodule
